// ==== common/pipePkg.sv ====
package pipePkg;

    localparam int WordWidth = 32;
    localparam int RegCount = 32;

    typedef logic [WordWidth-1:0] word_t;
    typedef logic [$clog2(RegCount)-1:0] regIdx_t;
    typedef logic [31:0] instr_t;
    typedef logic [4:0] shamt_t;

    // operand source select produced by forwarding
    typedef logic [1:0] fwdSel_t;

    // operations of one lane ALU
    typedef enum logic [2:0] {
        AluAdd,
        AluSub,
        AluAnd,
        AluOr,
        AluSlt,
        AluSll,
        AluSrl,
        AluPass
    } aluOp_t;

    // primary opcodes in instr[31:26]
    localparam logic [5:0] OpRType = 6'h00;
    localparam logic [5:0] OpAddi = 6'h08;
    localparam logic [5:0] OpSlti = 6'h0A;
    localparam logic [5:0] OpAndi = 6'h0C;
    localparam logic [5:0] OpOri = 6'h0D;

    // R-type function codes in instr[5:0]
    localparam logic [5:0] FnAdd = 6'h20;
    localparam logic [5:0] FnSub = 6'h22;
    localparam logic [5:0] FnAnd = 6'h24;
    localparam logic [5:0] FnOr = 6'h25;
    localparam logic [5:0] FnSlt = 6'h2A;
    localparam logic [5:0] FnSll = 6'h00;
    localparam logic [5:0] FnSrl = 6'h02;

    localparam regIdx_t ZeroReg = '0;

    localparam fwdSel_t FwdRegFile = 2'd0;
    localparam fwdSel_t FwdWb1 = 2'd1;
    localparam fwdSel_t FwdWb2 = 2'd2;

endpackage

// ==== issue/laneDecoder.sv ====
`timescale 1ns/1ps

module laneDecoder (
    input  pipePkg::instr_t  instr,
    output pipePkg::aluOp_t  aluOp,
    output pipePkg::regIdx_t srcA,
    output pipePkg::regIdx_t srcB,
    output logic             useImm,
    output pipePkg::word_t   immValue,
    output pipePkg::shamt_t  shamt,
    output logic             writeEn,
    output pipePkg::regIdx_t destReg
);

    logic [5:0] opcode;
    logic [5:0] funct;
    logic [15:0] imm;
    logic known;

    assign opcode = instr[31:26];
    assign funct = instr[5:0];
    assign imm = instr[15:0];

    assign srcA = instr[25:21];
    assign srcB = instr[20:16];
    assign shamt = instr[10:6];

    always_comb begin
        aluOp = pipePkg::AluPass;
        useImm = 1'b0;
        immValue = {{(pipePkg::WordWidth - 16){imm[15]}}, imm};
        destReg = instr[15:11];
        known = 1'b1;
        case (opcode)
            pipePkg::OpRType: begin
                case (funct)
                    pipePkg::FnAdd: aluOp = pipePkg::AluAdd;
                    pipePkg::FnSub: aluOp = pipePkg::AluSub;
                    pipePkg::FnAnd: aluOp = pipePkg::AluAnd;
                    pipePkg::FnOr:  aluOp = pipePkg::AluOr;
                    pipePkg::FnSlt: aluOp = pipePkg::AluSlt;
                    pipePkg::FnSll: aluOp = pipePkg::AluSll;
                    pipePkg::FnSrl: aluOp = pipePkg::AluSrl;
                    default:        known = 1'b0;
                endcase
            end
            pipePkg::OpAddi, pipePkg::OpSlti: begin
                // arithmetic immediates are signed
                aluOp = (opcode == pipePkg::OpAddi) ? pipePkg::AluAdd : pipePkg::AluSlt;
                useImm = 1'b1;
                destReg = instr[20:16];
            end
            pipePkg::OpAndi, pipePkg::OpOri: begin
                // logic immediates are zero-extended
                aluOp = (opcode == pipePkg::OpAndi) ? pipePkg::AluAnd : pipePkg::AluOr;
                useImm = 1'b1;
                immValue = {{(pipePkg::WordWidth - 16){1'b0}}, imm};
                destReg = instr[20:16];
            end
            default: known = 1'b0;
        endcase
    end

    // unknown encodings and writes to r0 retire as no-ops
    assign writeEn = known && (destReg != pipePkg::ZeroReg);

endmodule

// ==== issue/issueControl.sv ====
`timescale 1ns/1ps

module issueControl (
    input  logic             clk,
    input  logic             rst,
    input  logic             pairValid,
    input  pipePkg::instr_t  instr1In,
    input  pipePkg::instr_t  instr2In,
    output logic             pairReady,
    output logic             laneValid1,
    output pipePkg::aluOp_t  aluOp1,
    output pipePkg::regIdx_t srcA1,
    output pipePkg::regIdx_t srcB1,
    output logic             useImm1,
    output pipePkg::word_t   immValue1,
    output pipePkg::shamt_t  shamt1,
    output logic             writeEn1,
    output pipePkg::regIdx_t destReg1,
    output logic             laneValid2,
    output pipePkg::aluOp_t  aluOp2,
    output pipePkg::regIdx_t srcA2,
    output pipePkg::regIdx_t srcB2,
    output logic             useImm2,
    output pipePkg::word_t   immValue2,
    output pipePkg::shamt_t  shamt2,
    output logic             writeEn2,
    output pipePkg::regIdx_t destReg2
);

    pipePkg::instr_t instr1Q;
    pipePkg::instr_t instr2Q;
    logic valid1Q;
    logic valid2Q;
    logic hazard;

    laneDecoder decode1 (
        .instr(instr1Q), .aluOp(aluOp1), .srcA(srcA1), .srcB(srcB1), .useImm(useImm1),
        .immValue(immValue1), .shamt(shamt1), .writeEn(writeEn1), .destReg(destReg1)
    );

    laneDecoder decode2 (
        .instr(instr2Q), .aluOp(aluOp2), .srcA(srcA2), .srcB(srcB2), .useImm(useImm2),
        .immValue(immValue2), .shamt(shamt2), .writeEn(writeEn2), .destReg(destReg2)
    );

    // lane 2 reads what lane 1 writes, rt counts only for R-type
    assign hazard = valid1Q && valid2Q && writeEn1 &&
                    ((destReg1 == srcA2) || (!useImm2 && (destReg1 == srcB2)));

    assign laneValid1 = valid1Q;
    assign laneValid2 = valid2Q && !hazard;
    assign pairReady = !hazard;

    always_ff @(posedge clk) begin
        if (rst) begin
            valid1Q <= 1'b0;
            valid2Q <= 1'b0;
        end else if (hazard) begin
            // lane 1 has left, lane 2 stays one more cycle
            valid1Q <= 1'b0;
            valid2Q <= 1'b1;
        end else begin
            valid1Q <= pairValid;
            valid2Q <= pairValid;
        end
    end

    always_ff @(posedge clk) begin
        if (pairValid && pairReady) begin
            instr1Q <= instr1In;
            instr2Q <= instr2In;
        end
    end

    // a split costs exactly one cycle of input hold
    assert property (@(posedge clk) disable iff (rst) !pairReady |=> pairReady)
        else $error("pairReady low in two consecutive cycles");

endmodule

// ==== source/registerFile.sv ====
`timescale 1ns/1ps

module registerFile (
    input  logic             clk,
    input  logic             rst,
    input  pipePkg::regIdx_t readReg1,
    input  pipePkg::regIdx_t readReg2,
    input  pipePkg::regIdx_t readReg3,
    input  pipePkg::regIdx_t readReg4,
    output pipePkg::word_t   readData1,
    output pipePkg::word_t   readData2,
    output pipePkg::word_t   readData3,
    output pipePkg::word_t   readData4,
    input  logic             we1,
    input  pipePkg::regIdx_t wrReg1,
    input  pipePkg::word_t   wrData1,
    input  logic             we2,
    input  pipePkg::regIdx_t wrReg2,
    input  pipePkg::word_t   wrData2
);

    pipePkg::word_t regs [pipePkg::RegCount];

    // write-through, lane 2 is the later write
    function automatic pipePkg::word_t readPort(input pipePkg::regIdx_t idx);
        pipePkg::word_t value;
        if (idx == pipePkg::ZeroReg)
            value = '0;
        else if (we2 && wrReg2 == idx)
            value = wrData2;
        else if (we1 && wrReg1 == idx)
            value = wrData1;
        else
            value = regs[idx];
        return value;
    endfunction

    always_comb begin
        readData1 = readPort(readReg1);
        readData2 = readPort(readReg2);
        readData3 = readPort(readReg3);
        readData4 = readPort(readReg4);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < pipePkg::RegCount; i++) begin
                regs[i] <= '0;
            end
        end else begin
            if (we1 && wrReg1 != pipePkg::ZeroReg)
                regs[wrReg1] <= wrData1;
            // same register in both lanes, lane 2 lands last
            if (we2 && wrReg2 != pipePkg::ZeroReg)
                regs[wrReg2] <= wrData2;
        end
    end

    // the decoders keep r0 writes off the write-back ports
    assert property (@(posedge clk) disable iff (rst)
        !(we1 && wrReg1 == pipePkg::ZeroReg) && !(we2 && wrReg2 == pipePkg::ZeroReg))
        else $error("write-back to register zero");

endmodule

// ==== execute/forwardingUnit.sv ====
`timescale 1ns/1ps

module forwardingUnit (
    input  pipePkg::regIdx_t srcA1,
    input  pipePkg::regIdx_t srcB1,
    input  pipePkg::regIdx_t srcA2,
    input  pipePkg::regIdx_t srcB2,
    input  logic             wbValid1,
    input  logic             wbValid2,
    input  pipePkg::regIdx_t wbReg1,
    input  pipePkg::regIdx_t wbReg2,
    output pipePkg::fwdSel_t fwdA1,
    output pipePkg::fwdSel_t fwdB1,
    output pipePkg::fwdSel_t fwdA2,
    output pipePkg::fwdSel_t fwdB2
);

    // youngest value wins, so lane 2 is checked first
    function automatic pipePkg::fwdSel_t pickSource(input pipePkg::regIdx_t src);
        pipePkg::fwdSel_t sel;
        if (wbValid2 && wbReg2 == src)
            sel = pipePkg::FwdWb2;
        else if (wbValid1 && wbReg1 == src)
            sel = pipePkg::FwdWb1;
        else
            sel = pipePkg::FwdRegFile;
        return sel;
    endfunction

    always_comb begin
        fwdA1 = pickSource(srcA1);
        fwdB1 = pickSource(srcB1);
        fwdA2 = pickSource(srcA2);
        fwdB2 = pickSource(srcB2);
    end

endmodule

// ==== execute/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  pipePkg::word_t  operandA,
    input  pipePkg::word_t  operandB,
    input  pipePkg::shamt_t shamt,
    input  pipePkg::aluOp_t aluOp,
    output pipePkg::word_t  result
);

    logic lessThan;

    assign lessThan = $signed(operandA) < $signed(operandB);

    always_comb begin
        case (aluOp)
            pipePkg::AluAdd: result = operandA + operandB;
            pipePkg::AluSub: result = operandA - operandB;
            pipePkg::AluAnd: result = operandA & operandB;
            pipePkg::AluOr:  result = operandA | operandB;
            pipePkg::AluSlt: result = {{(pipePkg::WordWidth - 1){1'b0}}, lessThan};
            // shifts work on rt, as in MIPS
            pipePkg::AluSll: result = operandB << shamt;
            pipePkg::AluSrl: result = operandB >> shamt;
            default:         result = operandB;
        endcase
    end

endmodule

// ==== execute/executeStage.sv ====
`timescale 1ns/1ps

module executeStage (
    input  logic             clk,
    input  logic             rst,
    input  logic             laneValid1,
    input  pipePkg::aluOp_t  aluOp1,
    input  pipePkg::regIdx_t srcA1,
    input  pipePkg::regIdx_t srcB1,
    input  logic             useImm1,
    input  pipePkg::word_t   immValue1,
    input  pipePkg::shamt_t  shamt1,
    input  logic             writeEn1,
    input  pipePkg::regIdx_t destReg1,
    input  logic             laneValid2,
    input  pipePkg::aluOp_t  aluOp2,
    input  pipePkg::regIdx_t srcA2,
    input  pipePkg::regIdx_t srcB2,
    input  logic             useImm2,
    input  pipePkg::word_t   immValue2,
    input  pipePkg::shamt_t  shamt2,
    input  logic             writeEn2,
    input  pipePkg::regIdx_t destReg2,
    input  pipePkg::word_t   readData1,
    input  pipePkg::word_t   readData2,
    input  pipePkg::word_t   readData3,
    input  pipePkg::word_t   readData4,
    output logic             wbValid1,
    output pipePkg::regIdx_t wbReg1,
    output pipePkg::word_t   wbData1,
    output logic             wbValid2,
    output pipePkg::regIdx_t wbReg2,
    output pipePkg::word_t   wbData2
);

    logic exWrite1, exWrite2;
    pipePkg::aluOp_t exAluOp1, exAluOp2;
    pipePkg::regIdx_t exSrcA1, exSrcB1, exSrcA2, exSrcB2;
    logic exUseImm1, exUseImm2;
    pipePkg::word_t exImm1, exImm2;
    pipePkg::shamt_t exShamt1, exShamt2;
    pipePkg::regIdx_t exDest1, exDest2;
    pipePkg::word_t exRegA1, exRegB1, exRegA2, exRegB2;
    pipePkg::fwdSel_t fwdA1, fwdB1, fwdA2, fwdB2;
    pipePkg::word_t opA1, opB1, opA2, opB2;
    pipePkg::word_t result1, result2;

    // control of both lanes through execute and write-back
    always_ff @(posedge clk) begin
        if (rst) begin
            exWrite1 <= 1'b0;
            exWrite2 <= 1'b0;
            wbValid1 <= 1'b0;
            wbValid2 <= 1'b0;
        end else begin
            exWrite1 <= laneValid1 && writeEn1;
            exWrite2 <= laneValid2 && writeEn2;
            wbValid1 <= exWrite1;
            wbValid2 <= exWrite2;
        end
    end

    always_ff @(posedge clk) begin
        exAluOp1 <= aluOp1;
        exSrcA1 <= srcA1;
        exSrcB1 <= srcB1;
        exUseImm1 <= useImm1;
        exImm1 <= immValue1;
        exShamt1 <= shamt1;
        exDest1 <= destReg1;
        exRegA1 <= readData1;
        exRegB1 <= readData2;
        exAluOp2 <= aluOp2;
        exSrcA2 <= srcA2;
        exSrcB2 <= srcB2;
        exUseImm2 <= useImm2;
        exImm2 <= immValue2;
        exShamt2 <= shamt2;
        exDest2 <= destReg2;
        exRegA2 <= readData3;
        exRegB2 <= readData4;
        wbReg1 <= exDest1;
        wbData1 <= result1;
        wbReg2 <= exDest2;
        wbData2 <= result2;
    end

    forwardingUnit fwd (
        .srcA1(exSrcA1), .srcB1(exSrcB1), .srcA2(exSrcA2), .srcB2(exSrcB2),
        .wbValid1(wbValid1), .wbValid2(wbValid2), .wbReg1(wbReg1), .wbReg2(wbReg2),
        .fwdA1(fwdA1), .fwdB1(fwdB1), .fwdA2(fwdA2), .fwdB2(fwdB2)
    );

    function automatic pipePkg::word_t pickOperand(input pipePkg::fwdSel_t sel,
                                                   input pipePkg::word_t regValue);
        pipePkg::word_t value;
        case (sel)
            pipePkg::FwdWb1: value = wbData1;
            pipePkg::FwdWb2: value = wbData2;
            default:         value = regValue;
        endcase
        return value;
    endfunction

    // immediate replaces rt for I-type
    always_comb begin
        opA1 = pickOperand(fwdA1, exRegA1);
        opB1 = exUseImm1 ? exImm1 : pickOperand(fwdB1, exRegB1);
        opA2 = pickOperand(fwdA2, exRegA2);
        opB2 = exUseImm2 ? exImm2 : pickOperand(fwdB2, exRegB2);
    end

    alu alu1 (
        .operandA(opA1), .operandB(opB1), .shamt(exShamt1), .aluOp(exAluOp1), .result(result1)
    );

    alu alu2 (
        .operandA(opA2), .operandB(opB2), .shamt(exShamt2), .aluOp(exAluOp2), .result(result2)
    );

endmodule

// ==== source/dualIssueCore.sv ====
`timescale 1ns/1ps

module dualIssueCore (
    input  logic             clk,
    input  logic             rst,
    input  logic             pairValid,
    input  pipePkg::instr_t  instr1,
    input  pipePkg::instr_t  instr2,
    output logic             pairReady,
    output logic             wbValid1,
    output pipePkg::regIdx_t wbReg1,
    output pipePkg::word_t   wbData1,
    output logic             wbValid2,
    output pipePkg::regIdx_t wbReg2,
    output pipePkg::word_t   wbData2
);

    logic laneValid1, laneValid2;
    pipePkg::aluOp_t aluOp1, aluOp2;
    pipePkg::regIdx_t srcA1, srcB1, srcA2, srcB2;
    logic useImm1, useImm2;
    pipePkg::word_t immValue1, immValue2;
    pipePkg::shamt_t shamt1, shamt2;
    logic writeEn1, writeEn2;
    pipePkg::regIdx_t destReg1, destReg2;
    pipePkg::word_t readData1, readData2, readData3, readData4;

    issueControl issue (
        .clk(clk), .rst(rst), .pairValid(pairValid), .instr1In(instr1), .instr2In(instr2),
        .pairReady(pairReady),
        .laneValid1(laneValid1), .aluOp1(aluOp1), .srcA1(srcA1), .srcB1(srcB1),
        .useImm1(useImm1), .immValue1(immValue1), .shamt1(shamt1), .writeEn1(writeEn1),
        .destReg1(destReg1),
        .laneValid2(laneValid2), .aluOp2(aluOp2), .srcA2(srcA2), .srcB2(srcB2),
        .useImm2(useImm2), .immValue2(immValue2), .shamt2(shamt2), .writeEn2(writeEn2),
        .destReg2(destReg2)
    );

    // write ports are fed straight from write-back
    registerFile regFile (
        .clk(clk), .rst(rst),
        .readReg1(srcA1), .readReg2(srcB1), .readReg3(srcA2), .readReg4(srcB2),
        .readData1(readData1), .readData2(readData2),
        .readData3(readData3), .readData4(readData4),
        .we1(wbValid1), .wrReg1(wbReg1), .wrData1(wbData1),
        .we2(wbValid2), .wrReg2(wbReg2), .wrData2(wbData2)
    );

    executeStage execute (
        .clk(clk), .rst(rst),
        .laneValid1(laneValid1), .aluOp1(aluOp1), .srcA1(srcA1), .srcB1(srcB1),
        .useImm1(useImm1), .immValue1(immValue1), .shamt1(shamt1), .writeEn1(writeEn1),
        .destReg1(destReg1),
        .laneValid2(laneValid2), .aluOp2(aluOp2), .srcA2(srcA2), .srcB2(srcB2),
        .useImm2(useImm2), .immValue2(immValue2), .shamt2(shamt2), .writeEn2(writeEn2),
        .destReg2(destReg2),
        .readData1(readData1), .readData2(readData2),
        .readData3(readData3), .readData4(readData4),
        .wbValid1(wbValid1), .wbReg1(wbReg1), .wbData1(wbData1),
        .wbValid2(wbValid2), .wbReg2(wbReg2), .wbData2(wbData2)
    );

endmodule

// ==== test/tbClock.sv ====
`timescale 1ns/1ps

module tbClock (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reset covers the first two rising edges
    initial begin
        rst = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    end

endmodule

// ==== test/tbDualIssue.sv ====
`timescale 1ns/1ps

module tbDualIssue;

    localparam int Seed = 13579;
    localparam int PairCount = 400;
    localparam int PoolSize = 6;
    localparam int StartIdle = 3;
    localparam int QuietCycles = 5;
    // a pair needs at most one idle cycle, its accept cycle and one split cycle
    localparam int TimeoutCycles = 3 * PairCount + 50;

    logic clk;
    logic rst;
    logic pairValid;
    pipePkg::instr_t instr1;
    pipePkg::instr_t instr2;
    logic pairReady;
    logic wbValid1;
    pipePkg::regIdx_t wbReg1;
    pipePkg::word_t wbData1;
    logic wbValid2;
    pipePkg::regIdx_t wbReg2;
    pipePkg::word_t wbData2;

    pipePkg::word_t modelRegs [pipePkg::RegCount];
    pipePkg::regIdx_t expReg [$];
    pipePkg::word_t expData [$];

    int errorCount;
    int pairsAccepted;
    int writesSeen;
    int expectedSplits;
    int observedSplits;
    int cycleCount;
    int quietCount;
    logic offered;
    logic readyWasLow;

    tbClock clockGen (.clk(clk), .rst(rst));

    dualIssueCore UUT (
        .clk(clk), .rst(rst), .pairValid(pairValid), .instr1(instr1), .instr2(instr2),
        .pairReady(pairReady),
        .wbValid1(wbValid1), .wbReg1(wbReg1), .wbData1(wbData1),
        .wbValid2(wbValid2), .wbReg2(wbReg2), .wbData2(wbData2)
    );

    function automatic int unsigned randomBelow(input int unsigned n);
        return $urandom % n;
    endfunction

    // a small pool makes dependencies between lanes and pairs common
    function automatic pipePkg::regIdx_t randomReg();
        int unsigned v;
        v = randomBelow(PoolSize);
        return v[4:0];
    endfunction

    function automatic pipePkg::instr_t randomInstr();
        int unsigned pick;
        int unsigned bits;
        pipePkg::regIdx_t rs;
        pipePkg::regIdx_t rt;
        pipePkg::regIdx_t rd;
        logic [5:0] fn;
        pipePkg::instr_t word;
        pick = randomBelow(11);
        bits = $urandom;
        rs = randomReg();
        rt = randomReg();
        rd = randomReg();
        case (pick)
            0: fn = pipePkg::FnAdd;
            1: fn = pipePkg::FnSub;
            2: fn = pipePkg::FnAnd;
            3: fn = pipePkg::FnOr;
            4: fn = pipePkg::FnSlt;
            5: fn = pipePkg::FnSll;
            default: fn = pipePkg::FnSrl;
        endcase
        if (pick < 5)
            word = {pipePkg::OpRType, rs, rt, rd, 5'd0, fn};
        else if (pick < 7)
            // shifts keep rs at zero like a real encoding
            word = {pipePkg::OpRType, 5'd0, rt, rd, bits[4:0], fn};
        else if (pick == 7)
            word = {pipePkg::OpAddi, rs, rt, bits[15:0]};
        else if (pick == 8)
            word = {pipePkg::OpSlti, rs, rt, bits[15:0]};
        else if (pick == 9)
            word = {pipePkg::OpAndi, rs, rt, bits[15:0]};
        else
            word = {pipePkg::OpOri, rs, rt, bits[15:0]};
        return word;
    endfunction

    // architectural effect of one instruction on the model registers
    task automatic applyInstr(input pipePkg::instr_t instr);
        logic [5:0] opcode;
        pipePkg::regIdx_t dest;
        pipePkg::word_t a;
        pipePkg::word_t b;
        pipePkg::word_t signImm;
        pipePkg::word_t zeroImm;
        pipePkg::word_t value;
        opcode = instr[31:26];
        a = modelRegs[instr[25:21]];
        b = modelRegs[instr[20:16]];
        signImm = {{16{instr[15]}}, instr[15:0]};
        zeroImm = {16'h0000, instr[15:0]};
        dest = instr[20:16];
        value = '0;
        case (opcode)
            pipePkg::OpRType: begin
                dest = instr[15:11];
                case (instr[5:0])
                    pipePkg::FnAdd: value = a + b;
                    pipePkg::FnSub: value = a - b;
                    pipePkg::FnAnd: value = a & b;
                    pipePkg::FnOr:  value = a | b;
                    pipePkg::FnSlt: value = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    pipePkg::FnSll: value = b << instr[10:6];
                    pipePkg::FnSrl: value = b >> instr[10:6];
                    default:        dest = pipePkg::ZeroReg;
                endcase
            end
            pipePkg::OpAddi: value = a + signImm;
            pipePkg::OpSlti: value = ($signed(a) < $signed(signImm)) ? 32'd1 : 32'd0;
            pipePkg::OpAndi: value = a & zeroImm;
            pipePkg::OpOri:  value = a | zeroImm;
            default:         dest = pipePkg::ZeroReg;
        endcase
        // r0 is hardwired and its writes never retire
        if (dest != pipePkg::ZeroReg) begin
            modelRegs[dest] = value;
            expReg.push_back(dest);
            expData.push_back(value);
        end
    endtask

    // lane 2 has to wait when it reads the register lane 1 writes
    function automatic logic splitNeeded(input pipePkg::instr_t first,
                                         input pipePkg::instr_t second);
        pipePkg::regIdx_t dest;
        logic readsRt;
        dest = (first[31:26] == pipePkg::OpRType) ? first[15:11] : first[20:16];
        readsRt = (second[31:26] == pipePkg::OpRType);
        return (dest != pipePkg::ZeroReg) &&
               ((second[25:21] == dest) || (readsRt && second[20:16] == dest));
    endfunction

    task automatic applyPair(input pipePkg::instr_t first, input pipePkg::instr_t second);
        if (splitNeeded(first, second))
            expectedSplits++;
        applyInstr(first);
        applyInstr(second);
        pairsAccepted++;
    endtask

    task automatic checkLane(input int lane, input logic valid, input pipePkg::regIdx_t r,
                             input pipePkg::word_t d);
        pipePkg::regIdx_t wantReg;
        pipePkg::word_t wantData;
        if (valid) begin
            writesSeen++;
            if (r == pipePkg::ZeroReg) begin
                $display("Lane %0d retired a write to register zero", lane);
                errorCount++;
            end
            if (expReg.size() == 0) begin
                $display("Lane %0d wrote register %0d while no write was expected", lane, r);
                errorCount++;
            end else begin
                wantReg = expReg.pop_front();
                wantData = expData.pop_front();
                if (r != wantReg) begin
                    $display("Mismatch wbReg%0d: got %h, expected %h", lane, r, wantReg);
                    errorCount++;
                end
                if (d != wantData) begin
                    $display("Mismatch wbData%0d: got %h, expected %h", lane, d, wantData);
                    errorCount++;
                end
            end
        end
    endtask

    task automatic watchReady();
        if (!pairReady) begin
            observedSplits++;
            if (readyWasLow) begin
                $display("pairReady stayed low for two cycles in a row");
                errorCount++;
            end
        end
        readyWasLow = !pairReady;
    endtask

    // a refused pair stays on the inputs until it is taken
    task automatic driveInputs(input logic accepted);
        if (!pairValid || accepted) begin
            if (cycleCount < StartIdle || pairsAccepted == PairCount) begin
                pairValid = 1'b0;
            end else if (accepted && randomBelow(3) == 0) begin
                pairValid = 1'b0;
            end else begin
                pairValid = 1'b1;
                instr1 = randomInstr();
                instr2 = randomInstr();
            end
        end
    endtask

    initial begin
        pairValid = 1'b0;
        instr1 = '0;
        instr2 = '0;
        errorCount = 0;
        pairsAccepted = 0;
        writesSeen = 0;
        expectedSplits = 0;
        observedSplits = 0;
        cycleCount = 0;
        quietCount = 0;
        offered = 1'b0;
        readyWasLow = 1'b0;
        void'($urandom(Seed));
        for (int i = 0; i < pipePkg::RegCount; i++) begin
            modelRegs[i] = '0;
        end
        @(negedge rst);
        @(negedge clk);
        while (cycleCount < TimeoutCycles && quietCount < QuietCycles) begin
            checkLane(1, wbValid1, wbReg1, wbData1);
            checkLane(2, wbValid2, wbReg2, wbData2);
            watchReady();
            // inputs offered last cycle were taken at the rising edge just passed
            if (offered)
                applyPair(instr1, instr2);
            driveInputs(offered);
            offered = pairValid && pairReady;
            if (pairsAccepted == PairCount)
                quietCount++;
            cycleCount++;
            @(negedge clk);
        end
        if (quietCount < QuietCycles) begin
            $display("Timeout after %0d cycles with %0d pairs accepted and %0d writes pending",
                     cycleCount, pairsAccepted, expReg.size());
            errorCount++;
        end else if (expReg.size() != 0) begin
            $display("%0d expected writes never appeared", expReg.size());
            errorCount++;
        end
        if (observedSplits != expectedSplits) begin
            $display("Mismatch pairReady low cycles: got %h, expected %h",
                     observedSplits, expectedSplits);
            errorCount++;
        end
        if (expectedSplits == 0) begin
            $display("No pair was split during the run");
            errorCount++;
        end
        $display("Checks done: %0d errors, %0d pairs, %0d writes, %0d splits, %0d cycles",
                 errorCount, pairsAccepted, writesSeen, observedSplits, cycleCount);
        if (errorCount == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
common/pipePkg.sv
issue/laneDecoder.sv
issue/issueControl.sv
source/registerFile.sv
execute/forwardingUnit.sv
execute/alu.sv
execute/executeStage.sv
source/dualIssueCore.sv
test/tbClock.sv
test/tbDualIssue.sv

// ==== Makefile ====
SIM     := verilator
FLAGS   := --binary --timing --assert
TOP     := tbDualIssue
FLIST   := flist.f
OBJDIR  := obj_dir
BIN     := $(OBJDIR)/V$(TOP)
LOG     := sim.log
SOURCES := $(shell cat $(FLIST))

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FLIST)
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FLIST)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Result: FAILED" $(LOG) || ! grep -q "Result: PASSED" $(LOG); then \
		echo "simulation failed"; exit 1; fi

clean:
	rm -rf $(OBJDIR) $(LOG)
